// File: Makefile
TOP := ir_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module ir_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/ir_tb.sv
module ir_tb
  import ir_pkg::*;
;

  localparam int CLK_PER_SAMPLE = 4;
  localparam int HOLD_CYCLES    = 20;
  localparam int PULSE_SAMPLES  = 3;
  localparam int DEPTH_LOG2     = 4;
  localparam int DEPTH          = 2 ** DEPTH_LOG2;
  localparam int ACK_LIMIT      = 8;
  // Two shots of about 150 clocks each plus bus traffic, with a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  typedef logic [DEPTH_LOG2:0] adr_t;

  logic     clk_in;
  logic     rst_in;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  adr_t     wb_adr;
  wb_data_t wb_dat_w;
  logic [3:0] wb_sel;
  wb_data_t wb_dat_r;
  logic     wb_ack;
  sample_t  mic_in;
  sample_t  speaker_out;
  logic     sample_strobe;
  logic     impulse_mark;

  int         cycle_count = 0;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         mark_count = 0;
  logic       after_strobe = 1'b0;
  logic       armed = 1'b0;
  logic [15:0] lfsr = 16'd1;
  sample_t    rec_q[$];

  ir_top #(
    .CLK_PER_SAMPLE(CLK_PER_SAMPLE),
    .HOLD_CYCLES   (HOLD_CYCLES),
    .PULSE_SAMPLES (PULSE_SAMPLES),
    .DEPTH_LOG2    (DEPTH_LOG2)
  ) u_dut (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .mic_in       (mic_in),
    .speaker_out  (speaker_out),
    .sample_strobe(sample_strobe),
    .impulse_mark (impulse_mark)
  );

  always #2 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic wb_data_t sext(input sample_t s);
    return {{16{s[15]}}, s};
  endfunction

  task automatic check_eq(input string name, input wb_data_t expected, input wb_data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors found");
  endtask

  // --------------------
  // Microphone model
  // --------------------

  // Record on strobes after a mark, then present a fresh sample for the next strobe
  always @(negedge clk_in) begin
    logic [15:0] word;
    if (sample_strobe) begin
      if (impulse_mark) begin
        mark_count <= mark_count + 1;
        rec_q.delete();
        armed <= 1'b1;
      end else if (armed && rec_q.size() < DEPTH) begin
        rec_q.push_back(mic_in);
      end
    end
    if (after_strobe) begin
      word = '0;
      for (int i = 0; i < 16; i++) begin
        lfsr = lfsr_next(lfsr);
        word = {word[14:0], lfsr[0]};
      end
      mic_in <= sample_t'(word);
    end
    after_strobe <= sample_strobe;
  end

  // --------------------
  // Bus tasks
  // --------------------

  task automatic wb_access(input adr_t adr, input logic we, input wb_data_t data,
                           output wb_data_t rd);
    int n;
    @(negedge clk_in);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = 4'hf;
    n = 0;
    do begin
      @(negedge clk_in);
      n++;
    end while (!wb_ack && n < ACK_LIMIT);
    if (!wb_ack) begin
      errors++;
      $display("no bus ack within %0d cycles for address %h", ACK_LIMIT, adr);
    end
    rd = wb_dat_r;
    // Hold the request through the ack edge
    @(negedge clk_in);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input adr_t adr, input wb_data_t data);
    wb_data_t unused;
    wb_access(adr, 1'b1, data, unused);
  endtask

  task automatic wb_read(input adr_t adr, output wb_data_t data);
    wb_access(adr, 1'b0, '0, data);
  endtask

  task automatic wait_strobe();
    @(negedge clk_in);
    while (!sample_strobe) begin
      @(negedge clk_in);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_after_reset();
    int err_before;
    wb_data_t rd;
    err_before = errors;
    wb_read(adr_t'(REG_STATUS), rd);
    check_eq("status", 32'd0, rd);
    check_eq("speaker_out", 32'd0, sext(speaker_out));
    wb_write(adr_t'(REG_AMP), 32'h0000_1234);
    wb_read(adr_t'(REG_AMP), rd);
    check_eq("amplitude register", 32'h0000_1234, rd);
    end_test("after reset", err_before);
  endtask

  task automatic run_shot(input string name, input sample_t amp, input logic extra_start);
    int err_before;
    int start_cycle;
    int n;
    wb_data_t rd;
    wb_data_t expected;
    err_before = errors;
    wb_write(adr_t'(REG_AMP), sext(amp));
    wb_write(adr_t'(REG_CTRL), 32'd1 << CTRL_START_BIT);
    start_cycle = cycle_count;
    if (extra_start) begin
      wb_write(adr_t'(REG_CTRL), 32'd1 << CTRL_START_BIT);
      wb_read(adr_t'(REG_STATUS), rd);
      check_eq("status generator busy", 32'd1, {31'd0, rd[0]});
    end
    n = 0;
    while (!impulse_mark && n < HOLD_CYCLES + 4 * CLK_PER_SAMPLE) begin
      @(negedge clk_in);
      n++;
    end
    if (!impulse_mark) begin
      errors++;
      $display("impulse_mark never rose after the start command");
    end
    check_eq("mark after hold-off", 32'd1, {31'd0, (cycle_count - start_cycle) >= HOLD_CYCLES});
    check_eq("sample_strobe at mark", 32'd1, {31'd0, sample_strobe});
    // Pulse starts one clock after the mark strobe
    @(negedge clk_in);
    check_eq("speaker_out after mark", sext(amp), sext(speaker_out));
    for (n = 1; n <= PULSE_SAMPLES + 1; n++) begin
      wait_strobe();
      expected = (n <= PULSE_SAMPLES) ? sext(amp) : 32'd0;
      check_eq($sformatf("speaker_out at strobe %0d", n), expected, sext(speaker_out));
    end
    end_test(name, err_before);
  endtask

  task automatic read_buffer(input string name);
    int err_before;
    int n;
    wb_data_t rd;
    err_before = errors;
    n = 0;
    do begin
      wb_read(adr_t'(REG_STATUS), rd);
      n++;
    end while (!rd[2] && n < 100);
    if (!rd[2]) begin
      errors++;
      $display("recorder never reported done");
    end
    check_eq("recorded sample count", DEPTH, rec_q.size());
    for (int k = 0; k < DEPTH && k < rec_q.size(); k++) begin
      wb_read({1'b1, DEPTH_LOG2'(k)}, rd);
      check_eq($sformatf("buffer word %0d", k), sext(rec_q[k]), rd);
    end
    end_test(name, err_before);
  endtask

  task automatic test_clear_and_busy_start();
    int err_before;
    int marks_before;
    wb_data_t rd;
    err_before = errors;
    wb_write(adr_t'(REG_CTRL), 32'd1 << CTRL_CLEAR_BIT);
    wb_read(adr_t'(REG_STATUS), rd);
    check_eq("status after clear", 32'd0, rd);
    end_test("clear", err_before);
    marks_before = mark_count;
    err_before = errors;
    run_shot("negative pulse with extra start", -16'sd6000, 1'b1);
    read_buffer("second buffer");
    check_eq("marks in second shot", 32'd1, mark_count - marks_before);
    end_test("single mark", err_before);
  endtask

  initial begin
    clk_in   = 1'b0;
    rst_in   = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    mic_in   = '0;
    repeat (8) @(negedge clk_in);
    rst_in = 1'b0;

    test_after_reset();
    run_shot("positive pulse", 16'sh2000, 1'b0);
    read_buffer("first buffer");
    test_clear_and_busy_start();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: rtl/audio_step_gen.sv
module audio_step_gen #(
  parameter int CLK_PER_SAMPLE = 2500
) (
  input  logic clk_in,
  input  logic rst_in,
  output logic step
);

  localparam int CNT_W = (CLK_PER_SAMPLE > 1) ? $clog2(CLK_PER_SAMPLE) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_SAMPLE - 1);

  logic [CNT_W-1:0] div_cnt;
  logic             wrap;

  assign wrap = (div_cnt == CNT_LAST);

  // Free-running divider, one strobe per sample period
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      div_cnt <= '0;
      step    <= 1'b0;
    end else begin
      step <= wrap;
      if (wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// File: rtl/impulse_generator.sv
module impulse_generator
  import ir_pkg::*;
#(
  parameter int HOLD_CYCLES   = 140_000_000,
  parameter int PULSE_SAMPLES = 144
) (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    step,
  input  logic    start_pulse,
  input  sample_t amplitude,
  output logic    impulse_out,
  output sample_t amp_out,
  output logic    gen_busy
);

  localparam int HOLD_W  = $clog2(HOLD_CYCLES + 1);
  localparam int PULSE_W = $clog2(PULSE_SAMPLES + 1);

  localparam logic [HOLD_W-1:0]  HOLD_LAST  = HOLD_W'(HOLD_CYCLES - 1);
  localparam logic [PULSE_W-1:0] PULSE_LAST = PULSE_W'(PULSE_SAMPLES - 1);

  typedef enum logic [2:0] {
    WAITING,
    HOLDING,
    WILL_SEND,
    SENDING,
    SENT
  } gen_state_t;

  gen_state_t         state;
  logic [HOLD_W-1:0]  hold_cnt;
  logic [PULSE_W-1:0] pulse_cnt;
  sample_t            amp_q;

  // Mark is high during the strobe that starts the pulse
  assign impulse_out = (state == WILL_SEND) && step;
  assign gen_busy    = (state != WAITING);

  // Amplitude is frozen for the whole shot
  always_ff @(posedge clk_in) begin
    if (state == WAITING && start_pulse) begin
      amp_q <= amplitude;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= WAITING;
      hold_cnt  <= '0;
      pulse_cnt <= '0;
      amp_out   <= '0;
    end else begin
      case (state)
        WAITING: begin
          hold_cnt <= '0;
          if (start_pulse) begin
            state <= HOLDING;
          end
        end

        HOLDING: begin
          hold_cnt <= hold_cnt + 1'b1;
          if (hold_cnt == HOLD_LAST) begin
            state <= WILL_SEND;
          end
        end

        // Align the pulse start to the sample grid
        WILL_SEND: begin
          if (step) begin
            amp_out   <= amp_q;
            pulse_cnt <= '0;
            state     <= SENDING;
          end
        end

        SENDING: begin
          if (step) begin
            if (pulse_cnt == PULSE_LAST) begin
              amp_out <= '0;
              state   <= SENT;
            end else begin
              pulse_cnt <= pulse_cnt + 1'b1;
            end
          end
        end

        // One silent sample before rearming
        SENT: begin
          if (step) begin
            state <= WAITING;
          end
        end

        default: begin
          amp_out <= '0;
          state   <= WAITING;
        end
      endcase
    end
  end

endmodule

// File: rtl/ir_control.sv
module ir_control
  import ir_pkg::*;
#(
  parameter int DEPTH_LOG2 = 10
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [DEPTH_LOG2:0]   wb_adr,
  input  wb_data_t              wb_dat_w,
  input  logic [3:0]            wb_sel,
  input  logic                  gen_busy,
  input  logic                  rec_busy,
  input  logic                  rec_done,
  input  sample_t               rd_data,
  output wb_data_t              wb_dat_r,
  output logic                  wb_ack,
  output logic                  start_pulse,
  output logic                  clear_pulse,
  output sample_t               amplitude,
  output logic [DEPTH_LOG2-1:0] rd_addr
);

  // Top word address bit selects the buffer window
  localparam int BUF_SEL = DEPTH_LOG2;

  logic      req;
  logic      wr_commit;
  logic      buf_sel_q;
  reg_addr_t reg_idx;
  wb_data_t  reg_rd;
  wb_data_t  reg_rd_q;

  // --------------------
  // Bus handshake
  // --------------------

  // New request only outside the ack cycle
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign reg_idx = wb_adr[1:0];

  // Writes land on the ack edge, full words only
  assign wr_commit = wb_ack && wb_cyc && wb_stb && wb_we && (&wb_sel) && !wb_adr[BUF_SEL];

  // Buffer address goes straight to the synchronous read port
  assign rd_addr = wb_adr[DEPTH_LOG2-1:0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // --------------------
  // Read path
  // --------------------

  always_comb begin
    case (reg_idx)
      REG_STATUS: reg_rd = {29'd0, rec_done, rec_busy, gen_busy};
      REG_AMP:    reg_rd = {{16{amplitude[15]}}, amplitude};
      default:    reg_rd = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (req) begin
      reg_rd_q <= reg_rd;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      buf_sel_q <= 1'b0;
    end else if (req) begin
      buf_sel_q <= wb_adr[BUF_SEL];
    end
  end

  // Buffer words come back sign-extended
  assign wb_dat_r = buf_sel_q ? {{16{rd_data[15]}}, rd_data} : reg_rd_q;

  // --------------------
  // Write path
  // --------------------

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      amplitude   <= '0;
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
    end else begin
      // Command bits last a single clock
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
      if (wr_commit) begin
        case (reg_idx)
          REG_CTRL: begin
            start_pulse <= wb_dat_w[CTRL_START_BIT];
            clear_pulse <= wb_dat_w[CTRL_CLEAR_BIT];
          end
          REG_AMP: begin
            amplitude <= sample_t'(wb_dat_w[15:0]);
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/ir_pkg.sv
package ir_pkg;

  // --------------------
  // Datapath types
  // --------------------

  // Audio word for speaker, microphone and buffer
  typedef logic signed [15:0] sample_t;

  // Bus data word
  typedef logic [31:0] wb_data_t;

  // Register index inside the register window
  typedef logic [1:0] reg_addr_t;

  // --------------------
  // Register map
  // --------------------

  localparam reg_addr_t REG_CTRL   = 2'd0;
  localparam reg_addr_t REG_STATUS = 2'd1;
  localparam reg_addr_t REG_AMP    = 2'd2;

  // Control register bits, both self-clearing
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_CLEAR_BIT = 1;

endpackage

// File: rtl/ir_top.sv
module ir_top
  import ir_pkg::*;
#(
  parameter int CLK_PER_SAMPLE = 2500,
  parameter int HOLD_CYCLES    = 140_000_000,
  parameter int PULSE_SAMPLES  = 144,
  parameter int DEPTH_LOG2     = 10
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [DEPTH_LOG2:0] wb_adr,
  input  wb_data_t            wb_dat_w,
  input  logic [3:0]          wb_sel,
  output wb_data_t            wb_dat_r,
  output logic                wb_ack,
  input  sample_t             mic_in,
  output sample_t             speaker_out,
  output logic                sample_strobe,
  output logic                impulse_mark
);

  logic                  start_pulse;
  logic                  clear_pulse;
  sample_t               amplitude;
  logic [DEPTH_LOG2-1:0] rd_addr;
  sample_t               rd_data;
  logic                  gen_busy;
  logic                  rec_busy;
  logic                  rec_done;

  // Sample clock shared with the external codec
  audio_step_gen #(
    .CLK_PER_SAMPLE(CLK_PER_SAMPLE)
  ) u_step (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .step   (sample_strobe)
  );

  impulse_generator #(
    .HOLD_CYCLES  (HOLD_CYCLES),
    .PULSE_SAMPLES(PULSE_SAMPLES)
  ) u_gen (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step       (sample_strobe),
    .start_pulse(start_pulse),
    .amplitude  (amplitude),
    .impulse_out(impulse_mark),
    .amp_out    (speaker_out),
    .gen_busy   (gen_busy)
  );

  response_recorder #(
    .DEPTH_LOG2(DEPTH_LOG2)
  ) u_rec (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step       (sample_strobe),
    .impulse_in (impulse_mark),
    .clear_pulse(clear_pulse),
    .mic_in     (mic_in),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .busy       (rec_busy),
    .done       (rec_done)
  );

  ir_control #(
    .DEPTH_LOG2(DEPTH_LOG2)
  ) u_ctrl (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .gen_busy   (gen_busy),
    .rec_busy   (rec_busy),
    .rec_done   (rec_done),
    .rd_data    (rd_data),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .start_pulse(start_pulse),
    .clear_pulse(clear_pulse),
    .amplitude  (amplitude),
    .rd_addr    (rd_addr)
  );

endmodule

// File: rtl/response_recorder.sv
module response_recorder
  import ir_pkg::*;
#(
  parameter int DEPTH_LOG2 = 10
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  step,
  input  logic                  impulse_in,
  input  logic                  clear_pulse,
  input  sample_t               mic_in,
  input  logic [DEPTH_LOG2-1:0] rd_addr,
  output sample_t               rd_data,
  output logic                  busy,
  output logic                  done
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  // --------------------
  // Capture control
  // --------------------

  sample_t               mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic                  wr_en;
  logic                  last_wr;

  // The mark strobe itself is not recorded
  assign wr_en   = busy && step && !impulse_in;
  assign last_wr = (wr_ptr == '1);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      wr_ptr <= '0;
    end else if (impulse_in) begin
      // A new mark restarts the capture
      busy   <= 1'b1;
      done   <= 1'b0;
      wr_ptr <= '0;
    end else begin
      if (clear_pulse) begin
        done <= 1'b0;
      end
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (last_wr) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // Sample buffer
  // --------------------

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      mem[wr_ptr] <= mic_in;
    end
  end

  // Registered read, one clock of latency
  always_ff @(posedge clk_in) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src.f
rtl/ir_pkg.sv
rtl/audio_step_gen.sv
rtl/impulse_generator.sv
rtl/response_recorder.sv
rtl/ir_control.sv
rtl/ir_top.sv
bench/ir_tb.sv
